// File: design/axi_lite_master.sv
module axi_lite_master
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // request from the arbiter
  input  logic              start_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              done_o,
  // write address
  output logic [ADDR_W-1:0] m_axi_awaddr_o,
  output logic              m_axi_awvalid_o,
  input  logic              m_axi_awready_i,
  // write data
  output logic [DATA_W-1:0] m_axi_wdata_o,
  output logic [STRB_W-1:0] m_axi_wstrb_o,
  output logic              m_axi_wvalid_o,
  input  logic              m_axi_wready_i,
  // write response
  input  logic [1:0]        m_axi_bresp_i,
  input  logic              m_axi_bvalid_i,
  output logic              m_axi_bready_o,
  // read address
  output logic [ADDR_W-1:0] m_axi_araddr_o,
  output logic              m_axi_arvalid_o,
  input  logic              m_axi_arready_i,
  // read data
  input  logic [DATA_W-1:0] m_axi_rdata_i,
  input  logic [1:0]        m_axi_rresp_i,
  input  logic              m_axi_rvalid_i,
  output logic              m_axi_rready_o
);

  logic              busy_q;
  logic              we_q;
  logic              awvalid_q;
  logic              wvalid_q;
  logic              arvalid_q;
  logic              done_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic [DATA_W-1:0] rdata_q;
  logic              b_hs;
  logic              r_hs;

  assign b_hs = m_axi_bvalid_i && m_axi_bready_o;
  assign r_hs = m_axi_rvalid_i && m_axi_rready_o;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q    <= 1'b0;
      we_q      <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= b_hs || r_hs;
      if (start_i)
      begin
        busy_q    <= 1'b1;
        we_q      <= we_i;
        awvalid_q <= we_i;
        wvalid_q  <= we_i;
        arvalid_q <= !we_i;
      end
      else
      begin
        // aw and w may finish in either order
        if (awvalid_q && m_axi_awready_i)
          awvalid_q <= 1'b0;
        if (wvalid_q && m_axi_wready_i)
          wvalid_q <= 1'b0;
        if (arvalid_q && m_axi_arready_i)
          arvalid_q <= 1'b0;
        if (b_hs || r_hs)
          busy_q <= 1'b0;
      end
    end
  end

  // request payload and read data
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (r_hs)
      rdata_q <= m_axi_rdata_i;
  end

  assign m_axi_awaddr_o  = addr_q;
  assign m_axi_awvalid_o = awvalid_q;
  assign m_axi_wdata_o   = wdata_q;
  assign m_axi_wstrb_o   = wstrb_q;
  assign m_axi_wvalid_o  = wvalid_q;
  assign m_axi_araddr_o  = addr_q;
  assign m_axi_arvalid_o = arvalid_q;

  // response awaited once all address and data beats are accepted
  assign m_axi_bready_o = busy_q && we_q && !awvalid_q && !wvalid_q;
  assign m_axi_rready_o = busy_q && !we_q && !arvalid_q;

  assign rdata_o = rdata_q;
  assign done_o  = done_q;

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_axi_bvalid_i |-> (m_axi_bresp_i == RESP_OKAY));

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_axi_rvalid_i |-> (m_axi_rresp_i == RESP_OKAY));

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    start_i |-> !busy_q);

endmodule

// File: design/bus_arbiter.sv
module bus_arbiter
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // instruction fetch port
  input  logic              ifu_req_i,
  input  logic [ADDR_W-1:0] ifu_addr_i,
  output logic [DATA_W-1:0] ifu_rdata_o,
  output logic              ifu_rvalid_o,
  // load/store port
  input  logic              lsu_req_i,
  input  logic              lsu_we_i,
  input  logic [ADDR_W-1:0] lsu_addr_i,
  input  logic [DATA_W-1:0] lsu_wdata_i,
  input  logic [STRB_W-1:0] lsu_wstrb_i,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              lsu_done_o,
  // axi-lite master side
  output logic              mst_start_o,
  output logic              mst_we_o,
  output logic [ADDR_W-1:0] mst_addr_o,
  output logic [DATA_W-1:0] mst_wdata_o,
  output logic [STRB_W-1:0] mst_wstrb_o,
  input  logic [DATA_W-1:0] mst_rdata_i,
  input  logic              mst_done_i,
  // serial port
  output logic              uart_wen_o,
  output logic [DATA_W-1:0] uart_wdata_o,
  // timer
  output logic              clint_ren_o,
  output logic              clint_hi_sel_o,
  input  logic [DATA_W-1:0] clint_rdata_i
);

  logic [1:0] state_q;
  logic [1:0] tgt_q;
  logic       issued_q;
  logic [1:0] lcl_cnt_q;
  logic [1:0] lsu_tgt;
  logic       start;
  logic       lcl_done;
  logic       xfer_done;

  // uart takes stores only and mtime takes loads only
  always_comb
  begin
    if (lsu_we_i && (lsu_addr_i == UART_ADDR))
      lsu_tgt = TGT_UART;
    else if (!lsu_we_i && ((lsu_addr_i == MTIME_LO_ADDR) || (lsu_addr_i == MTIME_HI_ADDR)))
      lsu_tgt = TGT_CLINT;
    else
      lsu_tgt = TGT_MEM;
  end

  // first cycle of a grant kicks off the target
  assign start = (state_q != ARB_IDLE) && !issued_q;

  // uart finishes 1 cycle after start and clint 2 cycles after
  assign lcl_done  = issued_q && (tgt_q != TGT_MEM) && (lcl_cnt_q == 2'd1);
  assign xfer_done = issued_q && ((tgt_q == TGT_MEM) ? mst_done_i : lcl_done);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= ARB_IDLE;
      tgt_q     <= TGT_MEM;
      issued_q  <= 1'b0;
      lcl_cnt_q <= 2'd0;
    end
    else
    begin
      case (state_q)
        ARB_IDLE:
        begin
          issued_q <= 1'b0;
          // lsu wins a tie
          if (lsu_req_i)
          begin
            state_q <= ARB_LSU;
            tgt_q   <= lsu_tgt;
          end
          else if (ifu_req_i)
          begin
            state_q <= ARB_IFU;
            tgt_q   <= TGT_MEM;
          end
        end
        ARB_IFU, ARB_LSU:
        begin
          if (start)
          begin
            issued_q  <= 1'b1;
            lcl_cnt_q <= (tgt_q == TGT_CLINT) ? 2'd2 : 2'd1;
          end
          else if (xfer_done)
          begin
            // grant released only on completion
            state_q  <= ARB_IDLE;
            issued_q <= 1'b0;
          end
          else if (lcl_cnt_q != 2'd0)
          begin
            lcl_cnt_q <= lcl_cnt_q - 2'd1;
          end
        end
        default:
        begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

  // request steering
  assign mst_start_o  = start && (tgt_q == TGT_MEM);
  assign mst_we_o     = (state_q == ARB_LSU) && lsu_we_i;
  assign mst_addr_o   = (state_q == ARB_LSU) ? lsu_addr_i : ifu_addr_i;
  assign mst_wdata_o  = lsu_wdata_i;
  assign mst_wstrb_o  = lsu_wstrb_i;
  assign uart_wen_o   = start && (tgt_q == TGT_UART);
  assign uart_wdata_o = lsu_wdata_i;
  assign clint_ren_o  = start && (tgt_q == TGT_CLINT);
  assign clint_hi_sel_o = (lsu_addr_i == MTIME_HI_ADDR);

  // response steering to the granted client
  assign ifu_rdata_o  = mst_rdata_i;
  assign ifu_rvalid_o = (state_q == ARB_IFU) && xfer_done;
  assign lsu_rdata_o  = (tgt_q == TGT_CLINT) ? clint_rdata_i : mst_rdata_i;
  assign lsu_done_o   = (state_q == ARB_LSU) && xfer_done;

  // a master completion only belongs to an issued memory grant
  a_done_granted: assert property (@(posedge clk) disable iff (rst)
    mst_done_i |-> (issued_q && (state_q != ARB_IDLE) && (tgt_q == TGT_MEM)));

  // clients hold their request for the whole grant
  a_lsu_req_held: assert property (@(posedge clk) disable iff (rst)
    (state_q == ARB_LSU) |-> lsu_req_i);

  a_ifu_req_held: assert property (@(posedge clk) disable iff (rst)
    (state_q == ARB_IFU) |-> ifu_req_i);

endmodule

// File: design/bus_pkg.sv
package bus_pkg;

  // bus widths
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;
  localparam int MTIME_W = 64;

  // address map for lsu decode
  localparam logic [ADDR_W-1:0] UART_ADDR     = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = MTIME_LO_ADDR + 32'd4;

  // axi response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // arbiter grant state
  localparam logic [1:0] ARB_IDLE = 2'd0;
  localparam logic [1:0] ARB_IFU  = 2'd1;
  localparam logic [1:0] ARB_LSU  = 2'd2;

  // decoded lsu target
  // ifu grants always use TGT_MEM
  localparam logic [1:0] TGT_MEM   = 2'd0;
  localparam logic [1:0] TGT_UART  = 2'd1;
  localparam logic [1:0] TGT_CLINT = 2'd2;

endpackage

// File: design/bus_top.sv
module bus_top
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_req_i,
  input  logic [ADDR_W-1:0] ifu_addr_i,
  output logic [DATA_W-1:0] ifu_rdata_o,
  output logic              ifu_rvalid_o,
  input  logic              lsu_req_i,
  input  logic              lsu_we_i,
  input  logic [ADDR_W-1:0] lsu_addr_i,
  input  logic [DATA_W-1:0] lsu_wdata_i,
  input  logic [STRB_W-1:0] lsu_wstrb_i,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              lsu_done_o,
  output logic [ADDR_W-1:0] m_axi_awaddr_o,
  output logic              m_axi_awvalid_o,
  input  logic              m_axi_awready_i,
  output logic [DATA_W-1:0] m_axi_wdata_o,
  output logic [STRB_W-1:0] m_axi_wstrb_o,
  output logic              m_axi_wvalid_o,
  input  logic              m_axi_wready_i,
  input  logic [1:0]        m_axi_bresp_i,
  input  logic              m_axi_bvalid_i,
  output logic              m_axi_bready_o,
  output logic [ADDR_W-1:0] m_axi_araddr_o,
  output logic              m_axi_arvalid_o,
  input  logic              m_axi_arready_i,
  input  logic [DATA_W-1:0] m_axi_rdata_i,
  input  logic [1:0]        m_axi_rresp_i,
  input  logic              m_axi_rvalid_i,
  output logic              m_axi_rready_o,
  output logic [7:0]        uart_tx_data_o,
  output logic              uart_tx_valid_o
);

  logic              mst_start;
  logic              mst_we;
  logic [ADDR_W-1:0] mst_addr;
  logic [DATA_W-1:0] mst_wdata;
  logic [STRB_W-1:0] mst_wstrb;
  logic [DATA_W-1:0] mst_rdata;
  logic              mst_done;
  logic              uart_wen;
  logic [DATA_W-1:0] uart_wdata;
  logic              clint_ren;
  logic              clint_hi_sel;
  logic [DATA_W-1:0] clint_rdata;

  bus_arbiter u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_req_i      (ifu_req_i),
    .ifu_addr_i     (ifu_addr_i),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_req_i      (lsu_req_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_done_o     (lsu_done_o),
    .mst_start_o    (mst_start),
    .mst_we_o       (mst_we),
    .mst_addr_o     (mst_addr),
    .mst_wdata_o    (mst_wdata),
    .mst_wstrb_o    (mst_wstrb),
    .mst_rdata_i    (mst_rdata),
    .mst_done_i     (mst_done),
    .uart_wen_o     (uart_wen),
    .uart_wdata_o   (uart_wdata),
    .clint_ren_o    (clint_ren),
    .clint_hi_sel_o (clint_hi_sel),
    .clint_rdata_i  (clint_rdata)
  );

  axi_lite_master u_master (
    .clk             (clk),
    .rst             (rst),
    .start_i         (mst_start),
    .we_i            (mst_we),
    .addr_i          (mst_addr),
    .wdata_i         (mst_wdata),
    .wstrb_i         (mst_wstrb),
    .rdata_o         (mst_rdata),
    .done_o          (mst_done),
    .m_axi_awaddr_o  (m_axi_awaddr_o),
    .m_axi_awvalid_o (m_axi_awvalid_o),
    .m_axi_awready_i (m_axi_awready_i),
    .m_axi_wdata_o   (m_axi_wdata_o),
    .m_axi_wstrb_o   (m_axi_wstrb_o),
    .m_axi_wvalid_o  (m_axi_wvalid_o),
    .m_axi_wready_i  (m_axi_wready_i),
    .m_axi_bresp_i   (m_axi_bresp_i),
    .m_axi_bvalid_i  (m_axi_bvalid_i),
    .m_axi_bready_o  (m_axi_bready_o),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o)
  );

  uart_tx_port u_uart (
    .clk             (clk),
    .rst             (rst),
    .wen_i           (uart_wen),
    .wdata_i         (uart_wdata),
    .uart_tx_data_o  (uart_tx_data_o),
    .uart_tx_valid_o (uart_tx_valid_o)
  );

  clint_timer u_clint (
    .clk      (clk),
    .rst      (rst),
    .ren_i    (clint_ren),
    .hi_sel_i (clint_hi_sel),
    .rdata_o  (clint_rdata)
  );

endmodule

// File: design/clint_timer.sv
module clint_timer
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              ren_i,
  input  logic              hi_sel_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [MTIME_W-1:0] mtime_q;
  logic [DATA_W-1:0]  hi_hold_q;
  logic [DATA_W-1:0]  rdata_q;

  // free-running mtime, plus the high half saved at each low read
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q   <= '0;
      hi_hold_q <= '0;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
      if (ren_i && !hi_sel_i)
        hi_hold_q <= mtime_q[MTIME_W-1:DATA_W];
    end
  end

  // high read returns the half paired with the last low read
  always_ff @(posedge clk)
  begin
    if (ren_i)
    begin
      if (hi_sel_i)
        rdata_q <= hi_hold_q;
      else
        rdata_q <= mtime_q[DATA_W-1:0];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: design/uart_tx_port.sv
module uart_tx_port
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              wen_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [7:0]        uart_tx_data_o,
  output logic              uart_tx_valid_o
);

  logic [7:0]  data_q;
  logic        valid_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      // one valid pulse per accepted write
      valid_q <= wen_i;
    end
  end

  // only the low byte goes out
  always_ff @(posedge clk)
  begin
    if (wen_i)
      data_q <= wdata_i[7:0];
  end

  assign uart_tx_data_o  = data_q;
  assign uart_tx_valid_o = valid_q;

endmodule

// File: run.sh
#!/bin/sh
# build and run the bus testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module bus_top_tb -o bus_top_sim \
  && ./obj_dir/bus_top_sim \
  || exit 1

// File: src.f
+incdir+verification
design/bus_pkg.sv
design/uart_tx_port.sv
design/clint_timer.sv
design/axi_lite_master.sv
design/bus_arbiter.sv
design/bus_top.sv
verification/bus_top_tb.sv

// File: verification/bus_tests.svh
  // fetch one word and hold the request until rvalid
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data);
    ifu_addr = addr;
    ifu_req  = 1'b1;
    do
    begin
      @(negedge clk);
    end
    while (!ifu_rvalid);
    data = ifu_rdata;
    @(posedge clk);
    #2;
    ifu_req = 1'b0;
  endtask

  // lat counts edges from the edge that samples the request to the done edge
  task automatic lsu_access(input logic we, input logic [31:0] addr, input logic [31:0] wd,
                            input logic [3:0] strb, output logic [31:0] data, output int lat);
    lsu_we    = we;
    lsu_addr  = addr;
    lsu_wdata = wd;
    lsu_wstrb = strb;
    lsu_req   = 1'b1;
    lat       = -1;
    do
    begin
      @(negedge clk);
      lat = lat + 1;
    end
    while (!lsu_done);
    data = lsu_rdata;
    @(posedge clk);
    #2;
    lsu_req = 1'b0;
  endtask

  task automatic test_fetch();
    logic [31:0] addr;
    logic [31:0] data;
    for (int i = 0; i < 8; i++)
    begin
      addr = 32'h8000_0000 + 32'h0000_1004 * i;
      fetch_word(addr, data);
      check_eq("fetch", fill_word(addr), data);
    end
  endtask

  task automatic test_store_load();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb [5];
    int          lat;
    strb[0] = 4'hF;
    strb[1] = 4'h3;
    strb[2] = 4'hC;
    strb[3] = 4'h1;
    strb[4] = 4'h8;
    for (int i = 0; i < 5; i++)
    begin
      addr = 32'h8000_2000 + 4 * i;
      lsu_access(1'b1, addr, 32'h1122_3300 + i, strb[i], data, lat);
    end
    for (int i = 0; i < 5; i++)
    begin
      addr = 32'h8000_2000 + 4 * i;
      lsu_access(1'b0, addr, 32'd0, 4'hF, data, lat);
      check_eq("store_load", merge_bytes(fill_word(addr), 32'h1122_3300 + i, strb[i]), data);
    end
  endtask

  task automatic test_uart();
    logic [31:0] data;
    int          lat;
    int          axi_before;
    int          pulses_before;
    axi_before    = axi_count;
    pulses_before = tx_pulses;
    lsu_access(1'b1, UART_ADDR, 32'h5A5A_13C7, 4'hF, data, lat);
    check_eq("uart_latency", 2, lat);
    // a stretched valid would be counted again here
    repeat (2)
      @(posedge clk);
    #2;
    check_eq("uart_pulses", pulses_before + 1, tx_pulses);
    check_eq("uart_byte", 32'h0000_00C7, {24'd0, tx_byte});
    check_eq("uart_axi_count", axi_before, axi_count);
  endtask

  task automatic test_mtime();
    logic [31:0] lo_a;
    logic [31:0] lo_b;
    logic [31:0] hi_word;
    int          lat;
    int          axi_before;
    axi_before = axi_count;
    lsu_access(1'b0, MTIME_LO_ADDR, 32'd0, 4'hF, lo_a, lat);
    check_eq("mtime_lo_latency", 3, lat);
    lsu_access(1'b0, MTIME_LO_ADDR, 32'd0, 4'hF, lo_b, lat);
    check_eq("mtime_lo_latency", 3, lat);
    check_eq("mtime_increases", 32'd1, {31'd0, lo_b > lo_a});
    lsu_access(1'b0, MTIME_HI_ADDR, 32'd0, 4'hF, hi_word, lat);
    check_eq("mtime_hi_latency", 3, lat);
    check_eq("mtime_hi", 32'd0, hi_word);
    check_eq("mtime_axi_count", axi_before, axi_count);
  endtask

  // both clients raise a memory request in the same cycle
  task automatic test_contend();
    logic [31:0] iaddr;
    logic [31:0] laddr;
    logic [31:0] idata;
    logic [31:0] ldata;
    logic        ifu_seen;
    logic        lsu_seen;
    logic        lsu_first;
    for (int r = 0; r < 6; r++)
    begin
      iaddr     = 32'h8000_4000 + 32'h10 * r;
      laddr     = iaddr + 32'h0800_0000;
      ifu_seen  = 1'b0;
      lsu_seen  = 1'b0;
      lsu_first = 1'b0;
      ifu_addr  = iaddr;
      lsu_we    = 1'b0;
      lsu_addr  = laddr;
      ifu_req   = 1'b1;
      lsu_req   = 1'b1;
      while (!(ifu_seen && lsu_seen))
      begin
        @(negedge clk);
        if (lsu_done)
        begin
          lsu_seen  = 1'b1;
          lsu_first = !ifu_seen;
          ldata     = lsu_rdata;
        end
        if (ifu_rvalid)
        begin
          ifu_seen = 1'b1;
          idata    = ifu_rdata;
        end
        @(posedge clk);
        #2;
        if (lsu_seen)
          lsu_req = 1'b0;
        if (ifu_seen)
          ifu_req = 1'b0;
      end
      check_eq("contend_order", 32'd1, {31'd0, lsu_first});
      check_eq("contend_lsu_data", fill_word(laddr), ldata);
      check_eq("contend_ifu_data", fill_word(iaddr), idata);
    end
  endtask

// File: verification/bus_top_tb.sv
module bus_top_tb
  import bus_pkg::*;
();

  localparam int          SEED           = 32'h4e492aea;
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] FILL_XOR       = 32'hA5A5_0000;

  logic              clk;
  logic              rst;
  logic              ifu_req;
  logic [ADDR_W-1:0] ifu_addr;
  logic [DATA_W-1:0] ifu_rdata;
  logic              ifu_rvalid;
  logic              lsu_req;
  logic              lsu_we;
  logic [ADDR_W-1:0] lsu_addr;
  logic [DATA_W-1:0] lsu_wdata;
  logic [STRB_W-1:0] lsu_wstrb;
  logic [DATA_W-1:0] lsu_rdata;
  logic              lsu_done;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;
  logic [7:0]        tx_data;
  logic              tx_valid;

  // memory model state
  logic [31:0]       mem [logic [31:0]];
  logic [31:0]       aw_addr_q;
  logic [31:0]       w_data_q;
  logic [3:0]        w_strb_q;
  logic [31:0]       ar_addr_q;
  logic              aw_got = 1'b0;
  logic              w_got = 1'b0;
  logic              aw_hs;
  logic              w_hs;
  logic              ar_hs;
  logic              b_hs;
  logic              r_hs;
  logic              aw_rdy_nxt;
  logic              w_rdy_nxt;
  logic              ar_rdy_nxt;
  int                aw_wait = -1;
  int                w_wait = -1;
  int                ar_wait = -1;
  int                axi_count = 0;
  int                seed = SEED;

  int                tx_pulses = 0;
  logic [7:0]        tx_byte;
  int                cycles = 0;

  bus_top UUT (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_i       (ifu_req),
    .ifu_addr_i      (ifu_addr),
    .ifu_rdata_o     (ifu_rdata),
    .ifu_rvalid_o    (ifu_rvalid),
    .lsu_req_i       (lsu_req),
    .lsu_we_i        (lsu_we),
    .lsu_addr_i      (lsu_addr),
    .lsu_wdata_i     (lsu_wdata),
    .lsu_wstrb_i     (lsu_wstrb),
    .lsu_rdata_o     (lsu_rdata),
    .lsu_done_o      (lsu_done),
    .m_axi_awaddr_o  (awaddr),
    .m_axi_awvalid_o (awvalid),
    .m_axi_awready_i (awready),
    .m_axi_wdata_o   (wdata),
    .m_axi_wstrb_o   (wstrb),
    .m_axi_wvalid_o  (wvalid),
    .m_axi_wready_i  (wready),
    .m_axi_bresp_i   (bresp),
    .m_axi_bvalid_i  (bvalid),
    .m_axi_bready_o  (bready),
    .m_axi_araddr_o  (araddr),
    .m_axi_arvalid_o (arvalid),
    .m_axi_arready_i (arready),
    .m_axi_rdata_i   (rdata),
    .m_axi_rresp_i   (rresp),
    .m_axi_rvalid_i  (rvalid),
    .m_axi_rready_o  (rready),
    .uart_tx_data_o  (tx_data),
    .uart_tx_valid_o (tx_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  function automatic logic [31:0] word_key(input logic [31:0] addr);
    return {addr[31:2], 2'b00};
  endfunction

  // untouched words read back as their address xor the fill constant
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return word_key(addr) ^ FILL_XOR;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(word_key(addr)))
      return mem[word_key(addr)];
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

  // ready rises 0 to 3 cycles after valid is seen, drops after the handshake
  function automatic logic next_ready(input logic valid, input logic hs, inout int wait_n);
    if (hs || !valid)
    begin
      wait_n = -1;
      return 1'b0;
    end
    if (wait_n < 0)
      wait_n = $random(seed) & 3;
    if (wait_n == 0)
      return 1'b1;
    wait_n = wait_n - 1;
    return 1'b0;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Errors found");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // axi4-lite memory, one transaction at a time
  initial
  begin
    awready = 1'b0;
    wready  = 1'b0;
    arready = 1'b0;
    bvalid  = 1'b0;
    bresp   = RESP_OKAY;
    rvalid  = 1'b0;
    rresp   = RESP_OKAY;
    rdata   = '0;
    forever
    begin
      // handshakes the coming edge will complete
      @(negedge clk);
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      ar_hs = arvalid && arready;
      b_hs  = bvalid && bready;
      r_hs  = rvalid && rready;
      if (aw_hs)
      begin
        aw_addr_q = awaddr;
        aw_got    = 1'b1;
      end
      if (w_hs)
      begin
        w_data_q = wdata;
        w_strb_q = wstrb;
        w_got    = 1'b1;
      end
      if (ar_hs)
        ar_addr_q = araddr;
      aw_rdy_nxt = next_ready(awvalid, aw_hs, aw_wait);
      w_rdy_nxt  = next_ready(wvalid, w_hs, w_wait);
      ar_rdy_nxt = next_ready(arvalid, ar_hs, ar_wait);
      @(posedge clk);
      #2;
      awready = aw_rdy_nxt;
      wready  = w_rdy_nxt;
      arready = ar_rdy_nxt;
      if (b_hs)
        bvalid = 1'b0;
      if (r_hs)
        rvalid = 1'b0;
      if (aw_got && w_got)
      begin
        mem[word_key(aw_addr_q)] = merge_bytes(read_word(aw_addr_q), w_data_q, w_strb_q);
        aw_got    = 1'b0;
        w_got     = 1'b0;
        bvalid    = 1'b1;
        axi_count = axi_count + 1;
      end
      if (ar_hs)
      begin
        rdata     = read_word(ar_addr_q);
        rvalid    = 1'b1;
        axi_count = axi_count + 1;
      end
    end
  end

  // serial port byte monitor
  always @(negedge clk)
  begin
    if (tx_valid)
    begin
      tx_pulses = tx_pulses + 1;
      tx_byte   = tx_data;
    end
  end

  // limit far above the few hundred cycles the tests take
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $fatal(1, "stopped by timeout");
    end
  end

  `include "bus_tests.svh"

  initial
  begin
    rst       = 1'b1;
    ifu_req   = 1'b0;
    ifu_addr  = '0;
    lsu_req   = 1'b0;
    lsu_we    = 1'b0;
    lsu_addr  = '0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    repeat (16)
      @(posedge clk);
    #2;
    rst = 1'b0;
    test_fetch();
    test_store_load();
    test_uart();
    test_mtime();
    test_contend();
    $display("No errors");
    $finish;
  end

endmodule
